/* logic/filter_pkg.sv */
`default_nettype none

package filter_pkg;

    localparam int sample_w     = 16;
    localparam int coef_w       = 17;
    localparam int num_taps     = 32;
    localparam int tap_idx_w    = 5;
    localparam int num_banks    = 4;
    localparam int bank_w       = 2;
    localparam int acc_w        = 40;
    localparam int result_shift = 16;   // 32 taps of 0x800 sum to 1.0

    // symmetric low-pass set, tap 0 first
    localparam logic signed [coef_w-1:0] lowpass_coefs [num_taps] = '{
        17'h1FFFE, 17'h1FFF6, 17'h1FFDC, 17'h1FF9E,
        17'h1FF2A, 17'h1FE82, 17'h1FDCD, 17'h1FD70,
        17'h1FE07, 17'h00044, 17'h004AE, 17'h00B4E,
        17'h01380, 17'h01BF4, 17'h022F7, 17'h026F2,
        17'h026F2, 17'h022F7, 17'h01BF4, 17'h01380,
        17'h00B4E, 17'h004AE, 17'h00044, 17'h1FE07,
        17'h1FD70, 17'h1FDCD, 17'h1FE82, 17'h1FF2A,
        17'h1FF9E, 17'h1FFDC, 17'h1FFF6, 17'h1FFFE
    };

    function automatic logic signed [coef_w-1:0] default_coef(
        input logic [bank_w-1:0]    bank,
        input logic [tap_idx_w-1:0] tap
    );
        logic signed [coef_w-1:0] value;
        case (bank)
            2'd0:    value = 17'h00800;   // unity gain
            2'd1:    value = 17'h00400;   // half gain
            2'd2:    value = lowpass_coefs[tap];
            default: value = '0;
        endcase
        return value;
    endfunction

endpackage

`default_nettype wire

/* logic/regmap_pkg.sv */
`default_nettype none

package regmap_pkg;

    // word address: axis [8:7], bank [6:5], tap [4:0]
    localparam int wb_adr_w = 9;
    localparam int wb_dat_w = 32;   // coefficient in bits 16:0, sign-extended

    typedef enum logic [1:0] {
        axis_none = 2'd0,
        axis_x    = 2'd1,
        axis_y    = 2'd2,
        axis_z    = 2'd3
    } axis_t;

endpackage

`default_nettype wire

/* logic/sample_sequencer.sv */
`default_nettype none

module sample_sequencer
    import filter_pkg::*;
#(
    parameter int sample_period = 500
) (
    input  logic sys_clk,
    input  logic rst_n,
    input  logic busy_x,
    input  logic busy_y,
    input  logic busy_z,
    output logic fir_start,
    output logic available,
    output logic data_interrupt
);
    typedef enum logic [1:0] {
        seq_idle,
        seq_filter,
        seq_hold
    } seq_state_t;

    // never shorter than one filter pass plus handshake
    localparam int period  = (sample_period > num_taps + 4) ? sample_period : num_taps + 5;
    localparam int timer_w = $clog2(period);

    logic [timer_w-1:0] timer;
    logic               tick;
    logic               any_busy;
    seq_state_t         state;

    assign tick     = (timer == timer_w'(period - 1));
    assign any_busy = busy_x | busy_y | busy_z;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            timer <= '0;
        end else if (tick) begin
            timer <= '0;
        end else begin
            timer <= timer + 1'b1;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            state          <= seq_idle;
            fir_start      <= 1'b0;
            available      <= 1'b1;
            data_interrupt <= 1'b0;
        end else begin
            fir_start      <= 1'b0;
            data_interrupt <= 1'b0;
            case (state)
                seq_idle: begin
                    if (tick && available && !any_busy) begin   // else tick is dropped
                        fir_start <= 1'b1;
                        available <= 1'b0;
                        state     <= seq_filter;
                    end
                end
                seq_filter: begin
                    state <= seq_hold;   // filters raise busy on this edge
                end
                seq_hold: begin
                    if (!any_busy) begin
                        available      <= 1'b1;
                        data_interrupt <= 1'b1;
                        state          <= seq_idle;
                    end
                end
                default: state <= seq_idle;
            endcase
        end
    end

endmodule

`default_nettype wire

/* logic/coef_bank.sv */
`default_nettype none

module coef_bank
    import filter_pkg::*, regmap_pkg::*;
(
    input  logic                                 sys_clk,
    input  logic                                 rst_n,
    input  logic                                 wb_cyc,
    input  logic                                 wb_stb,
    input  logic                                 wb_we,
    input  logic [wb_adr_w-1:0]                  wb_adr,
    input  logic [regmap_pkg::wb_dat_w-1:0]      wb_dat_w,
    output logic [regmap_pkg::wb_dat_w-1:0]      wb_dat_r,
    output logic                                 wb_ack,
    input  logic [bank_w-1:0]                    x_bank,
    input  logic [bank_w-1:0]                    y_bank,
    input  logic [bank_w-1:0]                    z_bank,
    input  logic [tap_idx_w-1:0]                 x_tap,
    input  logic [tap_idx_w-1:0]                 y_tap,
    input  logic [tap_idx_w-1:0]                 z_tap,
    output logic signed [coef_w-1:0]             x_coef,
    output logic signed [coef_w-1:0]             y_coef,
    output logic signed [coef_w-1:0]             z_coef
);
    // indexed by axis_t code, axis_none has no storage
    logic signed [coef_w-1:0] coefs [1:3][num_banks][num_taps];

    axis_t                    adr_axis;
    logic [bank_w-1:0]        adr_bank;
    logic [tap_idx_w-1:0]     adr_tap;
    logic                     access;
    logic signed [coef_w-1:0] rd_coef;

    assign adr_axis = axis_t'(wb_adr[tap_idx_w + bank_w +: 2]);
    assign adr_bank = wb_adr[tap_idx_w +: bank_w];
    assign adr_tap  = wb_adr[tap_idx_w-1:0];
    assign access   = wb_cyc && wb_stb && !wb_ack;   // new cycle, not yet acked

    assign rd_coef = (adr_axis == axis_none) ? '0 : coefs[adr_axis][adr_bank][adr_tap];

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            wb_ack <= 1'b0;
            for (int a = 1; a <= 3; a++) begin
                for (int b = 0; b < num_banks; b++) begin
                    for (int t = 0; t < num_taps; t++) begin
                        coefs[a][b][t] <= default_coef(bank_w'(b), tap_idx_w'(t));
                    end
                end
            end
        end else begin
            wb_ack <= access;
            if (access && wb_we && adr_axis != axis_none) begin
                coefs[adr_axis][adr_bank][adr_tap] <= wb_dat_w[coef_w-1:0];
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (access) begin
            wb_dat_r <= {{(regmap_pkg::wb_dat_w - coef_w){rd_coef[coef_w-1]}}, rd_coef};
        end
    end

    // live taps for the filter lanes
    assign x_coef = coefs[axis_x][x_bank][x_tap];
    assign y_coef = coefs[axis_y][y_bank][y_tap];
    assign z_coef = coefs[axis_z][z_bank][z_tap];

endmodule

`default_nettype wire

/* logic/fir_mac.sv */
`default_nettype none

module fir_mac
    import filter_pkg::*;
(
    input  logic                        sys_clk,
    input  logic                        rst_n,
    input  logic                        fir_start,
    input  logic signed [sample_w-1:0]  sample,
    input  logic signed [coef_w-1:0]    coef,
    output logic [tap_idx_w-1:0]        tap,
    output logic                        busy,
    output logic signed [sample_w-1:0]  filter_data
);
    logic signed [sample_w-1:0]         history [num_taps];   // [0] is newest
    logic signed [acc_w-1:0]            acc;
    logic signed [sample_w+coef_w-1:0]  product;
    logic                               start;
    logic                               last_tap;

    assign start   = fir_start && !busy;
    assign product = history[tap] * coef;

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_taps; i++) begin
                history[i] <= '0;
            end
        end else if (start) begin
            history[0] <= sample;
            for (int i = 1; i < num_taps; i++) begin
                history[i] <= history[i-1];
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (start) begin
            acc <= '0;
        end else if (busy && !last_tap) begin
            acc <= acc + acc_w'(product);
        end
    end

    always_ff @(posedge sys_clk) begin
        if (!rst_n) begin
            busy        <= 1'b0;
            tap         <= '0;
            last_tap    <= 1'b0;
            filter_data <= '0;
        end else if (start) begin
            busy     <= 1'b1;
            tap      <= '0;
            last_tap <= 1'b0;
        end else if (last_tap) begin
            filter_data <= acc[result_shift +: sample_w];   // arithmetic shift, low 16 bits
            busy        <= 1'b0;
            last_tap    <= 1'b0;
        end else if (busy) begin
            tap <= tap + 1'b1;
            if (tap == tap_idx_w'(num_taps - 1)) begin
                last_tap <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* logic/accel_filter_top.sv */
`default_nettype none

module accel_filter_top
    import filter_pkg::*;
#(
    parameter int sample_period = 500
) (
    input  logic                                 sys_clk,
    input  logic                                 rst_n,
    input  logic signed [sample_w-1:0]           sample_x,
    input  logic signed [sample_w-1:0]           sample_y,
    input  logic signed [sample_w-1:0]           sample_z,
    input  logic [bank_w-1:0]                    x_bank,
    input  logic [bank_w-1:0]                    y_bank,
    input  logic [bank_w-1:0]                    z_bank,
    output logic signed [sample_w-1:0]           x_data,
    output logic signed [sample_w-1:0]           y_data,
    output logic signed [sample_w-1:0]           z_data,
    output logic                                 available,
    output logic                                 data_interrupt,
    input  logic                                 wb_cyc,
    input  logic                                 wb_stb,
    input  logic                                 wb_we,
    input  logic [regmap_pkg::wb_adr_w-1:0]      wb_adr,
    input  logic [regmap_pkg::wb_dat_w-1:0]      wb_dat_w,
    output logic [regmap_pkg::wb_dat_w-1:0]      wb_dat_r,
    output logic                                 wb_ack
);
    logic                     fir_start;
    logic                     busy_x;
    logic                     busy_y;
    logic                     busy_z;
    logic [tap_idx_w-1:0]     x_tap;
    logic [tap_idx_w-1:0]     y_tap;
    logic [tap_idx_w-1:0]     z_tap;
    logic signed [coef_w-1:0] x_coef;
    logic signed [coef_w-1:0] y_coef;
    logic signed [coef_w-1:0] z_coef;

    sample_sequencer #(
        .sample_period (sample_period)
    ) u_sequencer (
        .sys_clk        (sys_clk),
        .rst_n          (rst_n),
        .busy_x         (busy_x),
        .busy_y         (busy_y),
        .busy_z         (busy_z),
        .fir_start      (fir_start),
        .available      (available),
        .data_interrupt (data_interrupt)
    );

    coef_bank u_coef_bank (
        .sys_clk  (sys_clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .x_bank   (x_bank),
        .y_bank   (y_bank),
        .z_bank   (z_bank),
        .x_tap    (x_tap),
        .y_tap    (y_tap),
        .z_tap    (z_tap),
        .x_coef   (x_coef),
        .y_coef   (y_coef),
        .z_coef   (z_coef)
    );

    fir_mac u_fir_x (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .fir_start   (fir_start),
        .sample      (sample_x),
        .coef        (x_coef),
        .tap         (x_tap),
        .busy        (busy_x),
        .filter_data (x_data)
    );

    fir_mac u_fir_y (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .fir_start   (fir_start),
        .sample      (sample_y),
        .coef        (y_coef),
        .tap         (y_tap),
        .busy        (busy_y),
        .filter_data (y_data)
    );

    fir_mac u_fir_z (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .fir_start   (fir_start),
        .sample      (sample_z),
        .coef        (z_coef),
        .tap         (z_tap),
        .busy        (busy_z),
        .filter_data (z_data)
    );

endmodule

`default_nettype wire

/* tb/tb_ref_model.svh */
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

    // bank 2 defaults, tap 0 first
    localparam logic signed [16:0] lowpass_ref [32] = '{
        17'h1FFFE, 17'h1FFF6, 17'h1FFDC, 17'h1FF9E,
        17'h1FF2A, 17'h1FE82, 17'h1FDCD, 17'h1FD70,
        17'h1FE07, 17'h00044, 17'h004AE, 17'h00B4E,
        17'h01380, 17'h01BF4, 17'h022F7, 17'h026F2,
        17'h026F2, 17'h022F7, 17'h01BF4, 17'h01380,
        17'h00B4E, 17'h004AE, 17'h00044, 17'h1FE07,
        17'h1FD70, 17'h1FDCD, 17'h1FE82, 17'h1FF2A,
        17'h1FF9E, 17'h1FFDC, 17'h1FFF6, 17'h1FFFE
    };

    logic signed [16:0] coef_mirror [1:3][4][32];   // axis code, bank, tap
    logic signed [15:0] ref_hist [1:3][32];         // [0] is the newest sample

    function automatic void load_mirror();
        for (int a = 1; a <= 3; a++) begin
            for (int t = 0; t < 32; t++) begin
                ref_hist[a][t]       = '0;
                coef_mirror[a][0][t] = 17'h00800;
                coef_mirror[a][1][t] = 17'h00400;
                coef_mirror[a][2][t] = lowpass_ref[t];
                coef_mirror[a][3][t] = '0;
            end
        end
    endfunction

    function automatic void push_sample(input int a, input logic signed [15:0] s);
        for (int t = 31; t > 0; t--) begin
            ref_hist[a][t] = ref_hist[a][t-1];
        end
        ref_hist[a][0] = s;
    endfunction

    // full-precision sum, arithmetic shift, low 16 bits kept
    function automatic logic signed [15:0] filter_expect(input int a, input int b);
        longint sum;
        sum = 0;
        for (int t = 0; t < 32; t++) begin
            sum += longint'(ref_hist[a][t]) * longint'(coef_mirror[a][b][t]);
        end
        return 16'(sum >>> result_shift);
    endfunction

`endif

/* tb/tb_accel_filter.sv */
`default_nettype none

module tb_accel_filter
    import filter_pkg::*, regmap_pkg::*;
();
    localparam int sample_period  = 80;
    localparam int result_timeout = 400;   // cycles, several sample periods
    localparam int ack_timeout    = 16;

    logic                            sys_clk;
    logic                            rst_n;
    logic signed [sample_w-1:0]      sample_x;
    logic signed [sample_w-1:0]      sample_y;
    logic signed [sample_w-1:0]      sample_z;
    logic [bank_w-1:0]               x_bank;
    logic [bank_w-1:0]               y_bank;
    logic [bank_w-1:0]               z_bank;
    logic signed [sample_w-1:0]      x_data;
    logic signed [sample_w-1:0]      y_data;
    logic signed [sample_w-1:0]      z_data;
    logic                            available;
    logic                            data_interrupt;
    logic                            wb_cyc;
    logic                            wb_stb;
    logic                            wb_we;
    logic [wb_adr_w-1:0]             wb_adr;
    logic [regmap_pkg::wb_dat_w-1:0] wb_dat_w;
    logic [regmap_pkg::wb_dat_w-1:0] wb_dat_r;
    logic                            wb_ack;
    int                              result_count = 0;

    `include "tb_ref_model.svh"

    accel_filter_top #(
        .sample_period (sample_period)
    ) uut (.*);

    initial begin
        sys_clk = 1'b0;
        forever #2 sys_clk = ~sys_clk;
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    // one classic cycle, called on a falling edge
    task automatic wb_access(input logic we, input axis_t axis, input logic [1:0] bank,
                             input logic [4:0] tap, input logic [31:0] wdata,
                             output logic [31:0] rdata);
        int cycles;
        cycles   = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = {axis, bank, tap};
        wb_dat_w = wdata;
        do begin
            @(negedge sys_clk);
            cycles++;
            if (cycles > ack_timeout) begin
                $display("Timeout: the Wishbone access was never acknowledged");
                abort_run();
            end
        end while (!wb_ack);
        rdata  = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge sys_clk);
        check_value("wb_ack", 32'(wb_ack), 32'h0);   // ack is one cycle only
    endtask

    task automatic wb_write(input axis_t axis, input logic [1:0] bank, input logic [4:0] tap,
                            input logic [31:0] data);
        logic [31:0] rd_ignored;
        wb_access(1'b1, axis, bank, tap, data, rd_ignored);
        if (axis != axis_none) begin
            coef_mirror[int'(axis)][bank][tap] = data[coef_w-1:0];
        end
    endtask

    // wait for the next result, then present the samples for the following tick
    task automatic run_period(input logic signed [15:0] sx, input logic signed [15:0] sy,
                              input logic signed [15:0] sz);
        int start_count;
        int cycles;
        start_count = result_count;
        cycles      = 0;
        while (result_count == start_count) begin
            @(negedge sys_clk);
            cycles++;
            if (cycles > result_timeout) begin
                $display("Timeout: no filter result arrived");
                abort_run();
            end
        end
        @(negedge sys_clk);
        sample_x = sx;
        sample_y = sy;
        sample_z = sz;
    endtask

    initial begin : compare_results
        int   idle;
        logic prev_irq;
        logic saw_low;
        idle     = 0;
        prev_irq = 1'b0;
        saw_low  = 1'b0;
        forever begin
            @(negedge sys_clk);
            if (rst_n) begin
                idle++;
                if (idle > result_timeout) begin
                    $display("Timeout: data_interrupt did not arrive");
                    abort_run();
                end
                if (!available) saw_low = 1'b1;
                if (data_interrupt && prev_irq) begin
                    $display("data_interrupt stayed high for more than one cycle");
                    abort_run();
                end
                if (data_interrupt && !prev_irq) begin
                    if (!saw_low) begin
                        $display("available never went low before this interrupt");
                        abort_run();
                    end
                    check_value("available", 32'(available), 32'h1);
                    push_sample(1, sample_x);
                    push_sample(2, sample_y);
                    push_sample(3, sample_z);
                    check_value("x_data", 32'(x_data), 32'(filter_expect(1, int'(x_bank))));
                    check_value("y_data", 32'(y_data), 32'(filter_expect(2, int'(y_bank))));
                    check_value("z_data", 32'(z_data), 32'(filter_expect(3, int'(z_bank))));
                    saw_low = 1'b0;
                    idle    = 0;
                    result_count++;
                end
                prev_irq = data_interrupt;
            end
        end
    end

    initial begin : stimulus
        logic [31:0]        rd;
        logic signed [15:0] sx;
        void'($urandom(32'h1d81));
        rst_n     = 1'b0;
        sample_x  = 16'sh1000;
        sample_y  = -16'sh0800;
        sample_z  = 16'sh7FFF;
        x_bank    = 2'd0;
        y_bank    = 2'd0;
        z_bank    = 2'd0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        load_mirror();
        repeat (4) @(negedge sys_clk);
        rst_n = 1'b1;
        check_value("available", 32'(available), 32'h1);
        check_value("data_interrupt", 32'(data_interrupt), 32'h0);
        check_value("wb_ack", 32'(wb_ack), 32'h0);
        check_value("x_data", 32'(x_data), 32'h0);
        check_value("y_data", 32'(y_data), 32'h0);
        check_value("z_data", 32'(z_data), 32'h0);

        repeat (32) run_period(sample_x, sample_y, sample_z);   // unity gain ramp
        check_value("x_data", 32'(x_data), 32'(sample_x));
        check_value("y_data", 32'(y_data), 32'(sample_y));
        check_value("z_data", 32'(z_data), 32'(sample_z));

        wb_access(1'b0, axis_y, 2'd2, 5'd15, 32'h0, rd);
        check_value("wb_dat_r", rd, 32'h000026F2);
        wb_write(axis_x, 2'd3, 5'd7, 32'h0001ABCD);
        wb_access(1'b0, axis_x, 2'd3, 5'd7, 32'h0, rd);
        check_value("wb_dat_r", rd, 32'hFFFFABCD);   // bit 16 sign-extended
        wb_write(axis_none, 2'd1, 5'd3, 32'h00000123);
        wb_access(1'b0, axis_none, 2'd1, 5'd3, 32'h0, rd);
        check_value("wb_dat_r", rd, 32'h0);

        run_period(16'sh3000, 16'sh1234, 16'sh4000);
        x_bank = 2'd2;
        y_bank = 2'd3;
        z_bank = 2'd1;
        for (int p = 1; p < 34; p++) begin
            sx = ((p / 8) % 2 == 0) ? 16'sh3000 : -16'sh3000;   // slow square wave
            run_period(sx, 16'sh1234, 16'sh4000);
        end
        check_value("y_data", 32'(y_data), 32'h0);
        check_value("z_data", 32'(z_data), 32'h2000);

        run_period(sample_x, sample_y, sample_z);
        x_bank = 2'd0;
        y_bank = 2'd0;
        z_bank = 2'd0;
        for (int a = 1; a <= 3; a++) begin
            for (int t = 0; t < 32; t++) begin
                wb_write(axis_t'(2'(a)), 2'd3, 5'(t), $urandom() & 32'h0001FFFF);
            end
        end
        run_period(sample_x, sample_y, sample_z);
        x_bank = 2'd3;
        y_bank = 2'd3;
        z_bank = 2'd3;
        repeat (40) run_period(16'($urandom()), 16'($urandom()), 16'($urandom()));
        run_period(sample_x, sample_y, sample_z);   // last random set compared

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+tb
logic/filter_pkg.sv
logic/regmap_pkg.sv
logic/sample_sequencer.sv
logic/coef_bank.sv
logic/fir_mac.sv
logic/accel_filter_top.sv
tb/tb_accel_filter.sv

/* run_sim.sh */
#!/bin/sh
# build and run the accelerometer filter testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_accel_filter -f build.f

# the log decides the result, so a nonzero exit from $fatal is kept going here
./obj_dir/Vtb_accel_filter > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0
